// File: common/hci_copy_defines.svh
// ------------------------------
// widths and register map of the copy engine
// include wherever a width or an offset is needed
// ------------------------------
`ifndef HCI_COPY_DEFINES_SVH
`define HCI_COPY_DEFINES_SVH

`define HCI_COPY_DW 32      // tcdm data word
`define HCI_COPY_AW 16      // byte address, words are 4-byte aligned
`define HCI_COPY_NB_CHAN 2  // channel 0 is the load side, channel 1 the store side

// axi4-lite register offsets
`define REG_CTRL   16'h0000  // bit 0 start, write only
`define REG_STATUS 16'h0004  // bit 0 busy, bit 1 sticky done
`define REG_SRC    16'h0008
`define REG_DST    16'h000C
`define REG_LEN    16'h0010  // word count, zero finishes at once
`define REG_CFG    16'h0014  // bit 0 selects the two-lane add
`define REG_INC    16'h0018

`endif

// File: common/hci_copy_pkg.sv
// ------------------------------
// types shared by the copy engine blocks
// tcdm request and response, job config, fsm states
// ------------------------------
`include "hci_copy_defines.svh"

package hci_copy_pkg;

  typedef logic [`HCI_COPY_AW-1:0] addr_t;  // byte address on the tcdm port
  typedef logic [`HCI_COPY_DW-1:0] word_t;

  // request side of one tcdm port, fields stay put until gnt
  typedef struct packed {
    logic                      req;
    addr_t                     add;
    logic                      wen;   // high for a read, the hci convention
    word_t                     data;
    logic [`HCI_COPY_DW/8-1:0] be;
  } hci_req_t;

  typedef struct packed {
    logic  gnt;      // request taken in this cycle
    logic  r_valid;  // read data is on r_data
    word_t r_data;
  } hci_rsp_t;

  // job description as the host left it in the register file
  typedef struct packed {
    addr_t src;
    addr_t dst;
    addr_t len;     // in words
    logic  lane16;  // two independent 16-bit adds instead of one 32-bit add
    word_t inc;
  } copy_cfg_t;

  // the add unit reads a loaded word either as a whole or as two halves
  typedef union packed {
    word_t                         w;
    logic [1:0][`HCI_COPY_DW/2-1:0] h;  // h[0] is the low lane
  } data_word_u;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,   // load request out, waiting for gnt
    RD_WAIT,  // granted, waiting for r_valid
    WR_REQ,   // store request out, waiting for gnt
    NEXT      // step the counter, then loop or finish
  } copy_state_e;

endpackage

// File: hci_copy.f
+incdir+common
common/hci_copy_pkg.sv
hdl/hci_core_mux_static.sv
hdl/hci_copy_regfile.sv
hdl/copy_ctrl_fsm.sv
hdl/word_counter.sv
streamer/load_add_unit.sv
streamer/store_unit.sv
hdl/hci_copy_top.sv
tb/tb_clkgen.sv
tb/hci_copy_asserts.sv
tb/tb_hci_copy.sv

// File: hdl/copy_ctrl_fsm.sv
// ------------------------------
// sequences one read, add and write per word
// also owns the select of the shared tcdm mux
// ------------------------------
module copy_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  input  logic len_zero_i,
  input  logic last_i,      // the word being moved is the final one
  input  logic rd_gnt_i,    // load channel grant, ends RD_REQ
  input  logic rd_done_i,
  input  logic wr_done_i,
  output logic sel_o,
  output logic rd_start_o,
  output logic wr_start_o,
  output logic cnt_load_o,
  output logic cnt_step_o,
  output logic busy_o,
  output logic done_evt_o
);
  import hci_copy_pkg::*;

  copy_state_e state_q;
  copy_state_e state_d;
  logic        done_d;
  logic        done_q;

  always_comb begin
    state_d    = state_q;
    rd_start_o = 1'b0;
    wr_start_o = 1'b0;
    cnt_load_o = 1'b0;
    cnt_step_o = 1'b0;
    done_d     = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_i && len_zero_i) begin
          done_d = 1'b1;  // empty job, finish without touching memory
        end else if (start_i) begin
          cnt_load_o = 1'b1;
          rd_start_o = 1'b1;  // load unit raises req as we enter RD_REQ
          state_d    = RD_REQ;
        end
      end
      RD_REQ:  if (rd_gnt_i) state_d = RD_WAIT;
      RD_WAIT: begin
        if (rd_done_i) begin
          wr_start_o = 1'b1;  // result is registered by the same edge
          state_d    = WR_REQ;
        end
      end
      WR_REQ:  if (wr_done_i) state_d = NEXT;
      NEXT: begin
        cnt_step_o = 1'b1;
        if (last_i) begin
          done_d  = 1'b1;
          state_d = IDLE;
        end else begin
          rd_start_o = 1'b1;
          state_d    = RD_REQ;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;  // one-cycle event, busy is already low with it
    end
  end

  assign sel_o      = (state_q == WR_REQ);  // store channel only while writing
  assign busy_o     = (state_q != IDLE);
  assign done_evt_o = done_q;

endmodule

// File: hdl/hci_copy_regfile.sv
// ------------------------------
// axi4-lite target with the job and status registers
// a write of 1 to CTRL bit 0 launches a job when idle
// ------------------------------
`include "hci_copy_defines.svh"

module hci_copy_regfile (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  hci_copy_pkg::addr_t       s_awaddr_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  input  hci_copy_pkg::word_t       s_wdata_i,
  input  logic [`HCI_COPY_DW/8-1:0] s_wstrb_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  output logic [1:0]                s_bresp_o,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,
  input  hci_copy_pkg::addr_t       s_araddr_i,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,
  output hci_copy_pkg::word_t       s_rdata_o,
  output logic [1:0]                s_rresp_o,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,
  output hci_copy_pkg::copy_cfg_t   cfg_o,
  output logic                      start_o,
  input  logic                      busy_i,
  input  logic                      done_evt_i
);
  import hci_copy_pkg::*;

  copy_cfg_t cfg_q;
  logic      wr_acc;    // address and data taken together
  logic      rd_acc;
  logic      bvalid_q;
  logic      rvalid_q;
  logic      start_q;
  logic      done_q;    // sticky until the next start
  word_t     rd_mux;
  word_t     rdata_q;

  // merge the written bytes into the old register value
  function automatic word_t apply_strb(input word_t old_v, input word_t new_v,
                                       input logic [`HCI_COPY_DW/8-1:0] strb);
    word_t res;
    res = old_v;
    for (int b = 0; b < `HCI_COPY_DW/8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  // one write in flight at a time, the next waits for bready
  assign wr_acc = s_awvalid_i & s_wvalid_i & ~bvalid_q;
  assign rd_acc = s_arvalid_i & ~rvalid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_q    <= '0;
      start_q  <= 1'b0;
      done_q   <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      // start only from idle, a start written while busy is dropped
      start_q <= wr_acc && (s_awaddr_i == `REG_CTRL) && s_wstrb_i[0] && s_wdata_i[0] &&
                 !busy_i && !start_q;
      if (start_q) done_q <= 1'b0;
      else if (done_evt_i) done_q <= 1'b1;
      if (wr_acc) bvalid_q <= 1'b1;
      else if (s_bready_i) bvalid_q <= 1'b0;
      if (rd_acc) rvalid_q <= 1'b1;
      else if (s_rready_i) rvalid_q <= 1'b0;
      if (wr_acc) begin
        case (s_awaddr_i)  // unmapped offsets fall through unchanged
          `REG_SRC: cfg_q.src <= addr_t'(apply_strb(word_t'(cfg_q.src), s_wdata_i, s_wstrb_i));
          `REG_DST: cfg_q.dst <= addr_t'(apply_strb(word_t'(cfg_q.dst), s_wdata_i, s_wstrb_i));
          `REG_LEN: cfg_q.len <= addr_t'(apply_strb(word_t'(cfg_q.len), s_wdata_i, s_wstrb_i));
          `REG_CFG: if (s_wstrb_i[0]) cfg_q.lane16 <= s_wdata_i[0];
          `REG_INC: cfg_q.inc <= apply_strb(cfg_q.inc, s_wdata_i, s_wstrb_i);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (s_araddr_i)
      `REG_STATUS: rd_mux = word_t'({done_q, busy_i});
      `REG_SRC:    rd_mux = word_t'(cfg_q.src);
      `REG_DST:    rd_mux = word_t'(cfg_q.dst);
      `REG_LEN:    rd_mux = word_t'(cfg_q.len);
      `REG_CFG:    rd_mux = word_t'(cfg_q.lane16);
      `REG_INC:    rd_mux = cfg_q.inc;
      default:     rd_mux = '0;  // CTRL and holes read as zero
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) rdata_q <= rd_mux;  // sampled at acceptance, shown with rvalid
  end

  assign s_awready_o = wr_acc;
  assign s_wready_o  = wr_acc;
  assign s_arready_o = rd_acc;
  assign s_bvalid_o  = bvalid_q;
  assign s_bresp_o   = 2'b00;  // always OKAY
  assign s_rvalid_o  = rvalid_q;
  assign s_rdata_o   = rdata_q;
  assign s_rresp_o   = 2'b00;
  assign cfg_o       = cfg_q;
  assign start_o     = start_q;

endmodule

// File: hdl/hci_copy_top.sv
// ------------------------------
// copy engine top, one axi4-lite target and one tcdm port
// done_evt_o pulses once per finished job
// ------------------------------
`include "hci_copy_defines.svh"

module hci_copy_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  hci_copy_pkg::addr_t       s_awaddr_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  input  hci_copy_pkg::word_t       s_wdata_i,
  input  logic [`HCI_COPY_DW/8-1:0] s_wstrb_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  output logic [1:0]                s_bresp_o,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,
  input  hci_copy_pkg::addr_t       s_araddr_i,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,
  output hci_copy_pkg::word_t       s_rdata_o,
  output logic [1:0]                s_rresp_o,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,
  output hci_copy_pkg::hci_req_t    tcdm_req_o,
  input  hci_copy_pkg::hci_rsp_t    tcdm_rsp_i,
  output logic                      done_evt_o
);
  import hci_copy_pkg::*;

  copy_cfg_t                         cfg;
  hci_req_t [`HCI_COPY_NB_CHAN-1:0]  chan_req;  // 0 load, 1 store
  hci_rsp_t [`HCI_COPY_NB_CHAN-1:0]  chan_rsp;
  logic                              start;
  logic                              busy;
  logic                              done_evt;
  logic                              sel;
  logic                              rd_start;
  logic                              wr_start;
  logic                              rd_done;
  logic                              wr_done;
  logic                              cnt_load;
  logic                              cnt_step;
  logic                              last;
  addr_t                             offset;
  word_t                             result;

  hci_copy_regfile i_regfile (
    .clk_i, .rst_i,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o,
    .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
    .s_bresp_o, .s_bvalid_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .cfg_o      (cfg),
    .start_o    (start),
    .busy_i     (busy),
    .done_evt_i (done_evt)
  );

  copy_ctrl_fsm i_fsm (
    .clk_i, .rst_i,
    .start_i    (start),
    .len_zero_i (cfg.len == '0),
    .last_i     (last),
    .rd_gnt_i   (chan_rsp[0].gnt),
    .rd_done_i  (rd_done),
    .wr_done_i  (wr_done),
    .sel_o      (sel),
    .rd_start_o (rd_start),
    .wr_start_o (wr_start),
    .cnt_load_o (cnt_load),
    .cnt_step_o (cnt_step),
    .busy_o     (busy),
    .done_evt_o (done_evt)
  );

  word_counter i_counter (
    .clk_i, .rst_i,
    .load_i   (cnt_load),
    .step_i   (cnt_step),
    .len_i    (cfg.len),
    .last_o   (last),
    .offset_o (offset)
  );

  // both sides walk their range with the same offset
  load_add_unit i_load (
    .clk_i, .rst_i,
    .start_i    (rd_start),
    .addr_i     (cfg.src + offset),
    .inc_i      (cfg.inc),
    .lane16_i   (cfg.lane16),
    .tcdm_req_o (chan_req[0]),
    .tcdm_rsp_i (chan_rsp[0]),
    .result_o   (result),
    .done_o     (rd_done)
  );

  store_unit i_store (
    .clk_i, .rst_i,
    .start_i    (wr_start),
    .addr_i     (cfg.dst + offset),
    .data_i     (result),
    .tcdm_req_o (chan_req[1]),
    .tcdm_rsp_i (chan_rsp[1]),
    .done_o     (wr_done)
  );

  hci_core_mux_static #(
    .NB_CHAN (`HCI_COPY_NB_CHAN)
  ) i_mux (
    .clk_i, .rst_i,
    .clear_i   (1'b0),
    .sel_i     (sel),
    .in_req_i  (chan_req),
    .in_rsp_o  (chan_rsp),
    .out_req_o (tcdm_req_o),
    .out_rsp_i (tcdm_rsp_i)
  );

  assign done_evt_o = done_evt;

endmodule

// File: hdl/hci_core_mux_static.sv
// ------------------------------
// static tcdm mux for initiators that never overlap
// sel_i picks which channel owns the shared port
// ------------------------------
`include "hci_copy_defines.svh"

module hci_core_mux_static #(
  parameter int unsigned NB_CHAN = `HCI_COPY_NB_CHAN
) (
  input  logic                                  clk_i,    // no state inside
  input  logic                                  rst_i,
  input  logic                                  clear_i,  // tied low at the top
  input  logic [$clog2(NB_CHAN)-1:0]            sel_i,
  input  hci_copy_pkg::hci_req_t [NB_CHAN-1:0]  in_req_i,
  output hci_copy_pkg::hci_rsp_t [NB_CHAN-1:0]  in_rsp_o,
  output hci_copy_pkg::hci_req_t                out_req_o,
  input  hci_copy_pkg::hci_rsp_t                out_rsp_i
);

  // the handshake bits only reach the channel that owns the port, so an idle
  // channel never sees a grant that belongs to the other one
  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    assign in_rsp_o[ii].gnt     = (sel_i == ii) ? out_rsp_i.gnt : 1'b0;
    assign in_rsp_o[ii].r_valid = (sel_i == ii) ? out_rsp_i.r_valid : 1'b0;
    assign in_rsp_o[ii].r_data  = out_rsp_i.r_data;  // data is broadcast
  end

  assign out_req_o = in_req_i[sel_i];  // whole request of the owner

endmodule

// File: hdl/word_counter.sv
// ------------------------------
// remaining word count and byte offset of the job
// load at start, step once per finished word
// ------------------------------
module word_counter (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                load_i,
  input  logic                step_i,
  input  hci_copy_pkg::addr_t len_i,
  output logic                last_o,
  output hci_copy_pkg::addr_t offset_o
);
  import hci_copy_pkg::*;

  addr_t remain_q;  // words not yet finished, current one included
  addr_t offset_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || load_i) begin
      remain_q <= rst_i ? '0 : len_i;
      offset_q <= '0;
    end else if (step_i) begin
      remain_q <= remain_q - 1'b1;
      offset_q <= offset_q + addr_t'(4);  // next 32-bit word
    end
  end

  assign last_o   = (remain_q == addr_t'(1));
  assign offset_o = offset_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the copy engine testbench with Verilator and run it.
# The run fails if the log holds the fail line or lacks the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f hci_copy.f --top-module tb_hci_copy \
  -Mdir "$BUILD_DIR" -o sim_hci_copy
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_hci_copy" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
  echo "simulation ended without a pass line"
  exit 1
fi
exit 0

// File: streamer/load_add_unit.sv
// ------------------------------
// load side of the engine
// reads one word, adds the increment, holds the result
// ------------------------------
module load_add_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  hci_copy_pkg::addr_t    addr_i,    // stable for the whole read
  input  hci_copy_pkg::word_t    inc_i,
  input  logic                   lane16_i,
  output hci_copy_pkg::hci_req_t tcdm_req_o,
  input  hci_copy_pkg::hci_rsp_t tcdm_rsp_i,
  output hci_copy_pkg::word_t    result_o,
  output logic                   done_o
);
  import hci_copy_pkg::*;

  logic       pend_q;  // request out, no gnt yet
  logic       wait_q;  // granted, data not back yet
  data_word_u rd_word;
  data_word_u sum;
  word_t      result_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (start_i) pend_q <= 1'b1;
      else if (tcdm_rsp_i.gnt) pend_q <= 1'b0;
      if (pend_q && tcdm_rsp_i.gnt) wait_q <= 1'b1;
      else if (tcdm_rsp_i.r_valid) wait_q <= 1'b0;
    end
  end

  // same bits read two ways, lanes wrap on their own with no carry across
  always_comb begin
    rd_word.w = tcdm_rsp_i.r_data;
    sum.w     = rd_word.w + inc_i;
    if (lane16_i) begin
      sum.h[0] = rd_word.h[0] + inc_i[`HCI_COPY_DW/2-1:0];
      sum.h[1] = rd_word.h[1] + inc_i[`HCI_COPY_DW/2-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (done_o) result_q <= sum.w;
  end

  assign tcdm_req_o.req  = pend_q;
  assign tcdm_req_o.add  = addr_i;
  assign tcdm_req_o.wen  = 1'b1;  // read
  assign tcdm_req_o.data = '0;
  assign tcdm_req_o.be   = '1;
  assign done_o          = wait_q & tcdm_rsp_i.r_valid;  // result lands on this edge
  assign result_o        = result_q;

endmodule

// File: streamer/store_unit.sv
// ------------------------------
// store side of the engine
// writes the held result as one full word
// ------------------------------
module store_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  hci_copy_pkg::addr_t    addr_i,
  input  hci_copy_pkg::word_t    data_i,   // result register of the load side
  output hci_copy_pkg::hci_req_t tcdm_req_o,
  input  hci_copy_pkg::hci_rsp_t tcdm_rsp_i,
  output logic                   done_o
);

  logic pend_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) pend_q <= 1'b0;
    else if (start_i) pend_q <= 1'b1;
    else if (tcdm_rsp_i.gnt) pend_q <= 1'b0;  // a write is over at its grant
  end

  assign tcdm_req_o.req  = pend_q;
  assign tcdm_req_o.add  = addr_i;
  assign tcdm_req_o.wen  = 1'b0;
  assign tcdm_req_o.data = data_i;
  assign tcdm_req_o.be   = '1;  // always the whole word
  // r_valid never belongs to a write, only gnt matters here
  assign done_o          = pend_q & tcdm_rsp_i.gnt;

endmodule

// File: tb/hci_copy_asserts.sv
// ------------------------------
// protocol checks on the shared tcdm port and the fsm
// bound into hci_copy_top, reports only through $error
// ------------------------------
module hci_copy_asserts (
  input logic                      clk_i,
  input logic                      rst_i,
  input hci_copy_pkg::hci_req_t    req_i,
  input hci_copy_pkg::hci_rsp_t    rsp_i,
  input hci_copy_pkg::copy_state_e state_i,
  input logic                      sel_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import hci_copy_pkg::*;

  // an initiator keeps address, data and enables frozen until its grant
  req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.req && !rsp_i.gnt |=> req_i.req && $stable(req_i))
    else $error("tcdm request changed before its grant");

  idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    state_i == IDLE |-> !req_i.req)  // nothing goes out between jobs
    else $error("tcdm request raised while the fsm is idle");

  // a channel switch under a waiting request would hand it to the wrong unit
  sel_steady: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.req && !rsp_i.gnt |=> $stable(sel_i))
    else $error("mux select moved under a pending request");

endmodule

bind hci_copy_top hci_copy_asserts i_asserts (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .req_i   (tcdm_req_o),
  .rsp_i   (tcdm_rsp_i),
  .state_i (i_fsm.state_q),
  .sel_i   (sel)
);

// File: tb/tb_clkgen.sv
// ------------------------------
// clock and reset for the testbench
// 10 ns period, reset high over the first two edges
// ------------------------------
module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release on a falling edge, so the dut leaves reset on a clean rising edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: tb/tb_hci_copy.sv
// ------------------------------
// testbench for the copy engine
// axi4-lite host, tcdm memory with random delays and a reference model
// ------------------------------
`include "hci_copy_defines.svh"

module tb_hci_copy;
  timeunit 1ns;
  timeprecision 1ps;
  import hci_copy_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int AXI_TIMEOUT = 50;

  logic                      clk;
  logic                      rst;
  addr_t                     awaddr;
  logic                      awvalid;
  logic                      awready;
  word_t                     wdata;
  logic [`HCI_COPY_DW/8-1:0] wstrb;
  logic                      wvalid;
  logic                      wready;
  logic [1:0]                bresp;
  logic                      bvalid;
  logic                      bready;
  addr_t                     araddr;
  logic                      arvalid;
  logic                      arready;
  word_t                     rdata;
  logic [1:0]                rresp;
  logic                      rvalid;
  logic                      rready;
  hci_req_t                  tcdm_req;
  hci_rsp_t                  tcdm_rsp;
  logic                      done_evt;

  word_t  mem [MEM_WORDS];      // the tcdm itself
  word_t  exp_mem [MEM_WORDS];  // what the memory should hold after a job
  integer seed = 20;            // stimulus
  integer delay_seed = 20;      // grant and read delays, kept apart from the stimulus
  int     gnt_wait = -1;        // cycles left before the pending request is granted
  int     rd_wait = 0;          // cycles left before read data shows up
  word_t  rd_word;
  int     req_cycles = 0;
  int     done_cnt = 0;
  addr_t  reg_offs [5] = '{`REG_SRC, `REG_DST, `REG_LEN, `REG_CFG, `REG_INC};
  word_t  reg_masks [5] = '{32'hFFFF, 32'hFFFF, 32'hFFFF, 32'h1, 32'hFFFF_FFFF};

  tb_clkgen i_clkgen (.clk_o(clk), .rst_o(rst));

  hci_copy_top dut0 (
    .clk_i(clk), .rst_i(rst),
    .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
    .s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o(wready),
    .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
    .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
    .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
    .tcdm_req_o(tcdm_req), .tcdm_rsp_i(tcdm_rsp), .done_evt_o(done_evt)
  );

  // memory answers on the falling edge, grant after 0 to 3 cycles, data 1 to 3 later
  always @(negedge clk) begin
    tcdm_rsp.gnt = 1'b0;
    tcdm_rsp.r_valid = 1'b0;
    if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) begin
        tcdm_rsp.r_valid = 1'b1;
        tcdm_rsp.r_data = rd_word;
      end
    end
    if (!rst && tcdm_req.req) begin
      req_cycles++;
      if (gnt_wait < 0) gnt_wait = $unsigned($random(delay_seed)) % 4;
      if (gnt_wait == 0) begin
        tcdm_rsp.gnt = 1'b1;
        // every transfer moves one whole word
        check_eq(word_t'(tcdm_req.be), 32'hF, "tcdm byte enables");
        if (tcdm_req.wen) begin  // wen high is a read
          rd_word = mem[tcdm_req.add[9:2]];
          rd_wait = 1 + $unsigned($random(delay_seed)) % 3;
        end else begin
          mem[tcdm_req.add[9:2]] = tcdm_req.data;
        end
      end
      gnt_wait--;  // drops to -1 after a grant, ready for the next request
    end
    if (done_evt) done_cnt++;
  end

  task automatic check_eq(input word_t got, input word_t want, input string what);
    if (got !== want) begin
      $display("FAILED at %0d ns: %s, got %h expected %h", $time, what, got, want);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic give_up(input string what);
    $display("timed out waiting for %s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // address and data go out together, the response marks the acceptance
  task automatic write_reg(input addr_t addr, input word_t data);
    int n;
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    n = 0;
    while (!bvalid) begin
      @(negedge clk);
      n++;
      if (n > AXI_TIMEOUT) give_up("the axi write response");
    end
    check_eq(word_t'(bresp), 0, "write response code");
    awvalid = 1'b0;
    wvalid = 1'b0;
  endtask

  task automatic read_reg(input addr_t addr, output word_t data);
    int n;
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    rready = 1'b1;
    n = 0;
    while (!rvalid) begin
      @(negedge clk);
      n++;
      if (n > AXI_TIMEOUT) give_up("the axi read data");
    end
    check_eq(word_t'(rresp), 0, "read response code");
    data = rdata;
    arvalid = 1'b0;
  endtask

  // word mode wraps at 32 bits, lane mode adds the low half of inc to each half alone
  function automatic word_t predict_word(input word_t src, input word_t inc, input logic lanes);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = src[15:0] + inc[15:0];
    hi = src[31:16] + inc[15:0];
    if (lanes) return {hi, lo};
    else return src + inc;
  endfunction

  // program one job, wait for its end and compare the whole memory
  task automatic run_job(input int src_w, input int dst_w, input int len,
                         input logic lanes, input word_t inc, input logic probe);
    word_t st;
    int    n;
    int    done_before;
    int    req_before;
    exp_mem = mem;
    for (int i = 0; i < len; i++) exp_mem[dst_w + i] = predict_word(mem[src_w + i], inc, lanes);
    write_reg(`REG_SRC, word_t'(src_w * 4));
    write_reg(`REG_DST, word_t'(dst_w * 4));
    write_reg(`REG_LEN, word_t'(len));
    write_reg(`REG_CFG, word_t'(lanes));
    write_reg(`REG_INC, inc);
    done_before = done_cnt;
    req_before = req_cycles;
    write_reg(`REG_CTRL, 32'h1);
    if (probe) begin
      repeat (2) @(negedge clk);  // start pulse and fsm need two edges
      read_reg(`REG_STATUS, st);
      check_eq(st, 32'h1, "STATUS while the job runs");
      write_reg(`REG_CTRL, 32'h1);  // lands mid job and must not restart it
    end
    n = 0;
    while (done_cnt == done_before) begin
      @(negedge clk);
      n++;
      if (n > 100 + 60 * len) give_up("done_evt_o at the end of a job");
    end
    repeat (4) @(negedge clk);  // room for a stray second pulse
    check_eq(done_cnt - done_before, 1, "done events for one job");
    read_reg(`REG_STATUS, st);
    check_eq(st, 32'h2, "STATUS after the job");
    if (len == 0) check_eq(req_cycles - req_before, 0, "tcdm requests of an empty job");
    for (int i = 0; i < MEM_WORDS; i++) check_eq(mem[i], exp_mem[i], $sformatf("memory word %0d", i));
  endtask

  // source and destination sit in opposite halves so they never overlap
  task automatic random_job(input logic lanes);
    int len;
    int lo_w;
    int hi_w;
    len = 1 + $unsigned($random(seed)) % 16;
    lo_w = $unsigned($random(seed)) % (129 - len);
    hi_w = 128 + $unsigned($random(seed)) % (129 - len);
    if ($random(seed) & 1) run_job(lo_w, hi_w, len, lanes, $random(seed), 1'b0);
    else run_job(hi_w, lo_w, len, lanes, $random(seed), 1'b0);
  endtask

  initial begin
    word_t v;
    word_t got;
    int    n;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '1;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    tcdm_rsp = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = $random(seed);
    n = 0;
    while (rst !== 1'b0) begin  // reset may still be unknown at time zero
      @(negedge clk);
      n++;
      if (n > 10) give_up("the end of reset");
    end
    check_eq(word_t'({awready, wready, arready, bvalid, rvalid, done_evt, tcdm_req.req}), 0,
             "idle outputs after reset");
    read_reg(`REG_STATUS, got);
    check_eq(got, 0, "STATUS after reset");
    foreach (reg_offs[r]) begin
      v = $random(seed);
      write_reg(reg_offs[r], v);
      read_reg(reg_offs[r], got);
      check_eq(got, v & reg_masks[r], $sformatf("readback at offset %h", reg_offs[r]));
    end
    run_job(10, 140, 12, 1'b0, $random(seed), 1'b0);  // whole-word add
    mem[150] = 32'hFFFF_8000;  // both lanes wrap with the increment below
    run_job(150, 20, 9, 1'b1, {16'h1234, 16'hF00D}, 1'b0);
    run_job(40, 200, 8, 1'b0, 32'h0000_0101, 1'b1);  // busy probe and ignored restart
    run_job(60, 160, 0, 1'b0, 32'h5, 1'b0);  // empty job
    repeat (10) random_job($random(seed) & 1);
    $display("TESTS PASSED");
    $finish;
  end

endmodule
